/* src/dcache_mem_defs.svh */
//////////////////////////////
// geometry and width macros for the
// l1 data cache storage core
//////////////////////////////

`ifndef DCACHE_MEM_DEFS_SVH
`define DCACHE_MEM_DEFS_SVH

//////////////////////////////
// organisation
//////////////////////////////

// read ports competing for a lookup
`define DC_NUM_PORTS 3

// ways per set
`define DC_SET_ASSOC 4

// words per line and number of sram banks
`define DC_NUM_BANKS 4

// sets per way
`define DC_NUM_SETS 16

//////////////////////////////
// field widths
//////////////////////////////

`define DC_IDX_W 4
`define DC_TAG_W 8
`define DC_WORD_W 32

// word offset inside a line
`define DC_OFF_W 2

// wide enough to index any read port
`define DC_PORT_W 2

`endif

/* src/dcache_mem_pkg.sv */
//////////////////////////////
// shared types of the dcache
// storage core
//////////////////////////////

`include "dcache_mem_defs.svh"

package dcache_mem_pkg;

  typedef logic [`DC_WORD_W-1:0] dc_word_t;
  typedef logic [`DC_TAG_W-1:0]  dc_tag_t;
  typedef logic [`DC_IDX_W-1:0]  dc_idx_t;
  typedef logic [`DC_OFF_W-1:0]  dc_off_t;

  // one bit per way, bank or read port
  typedef logic [`DC_SET_ASSOC-1:0] dc_way_vec_t;
  typedef logic [`DC_NUM_BANKS-1:0] dc_bank_vec_t;
  typedef logic [`DC_NUM_PORTS-1:0] dc_port_vec_t;

  typedef logic [`DC_PORT_W-1:0] dc_port_sel_t;

  // full line, word 0 sits in the low bits
  typedef dc_word_t [`DC_NUM_BANKS-1:0] dc_line_t;

  // what the arrays do in the current cycle
  typedef enum logic [1:0] {
    BANK_IDLE     = 2'd0,
    BANK_REFILL   = 2'd1,
    BANK_READ     = 2'd2,
    BANK_TAG_READ = 2'd3
  } bank_op_e;

endpackage

/* src/dcache_req_arbiter.sv */
//////////////////////////////
// read port arbiter with priority masking
// and round robin, bank request decode
// and word write collision check
//////////////////////////////

`include "dcache_mem_defs.svh"

module dcache_req_arbiter import dcache_mem_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // read ports
  input  dc_port_vec_t                       rd_req_i,
  input  dc_port_vec_t                       rd_prio_i,
  input  dc_port_vec_t                       rd_tag_only_i,
  input  dc_idx_t      [`DC_NUM_PORTS-1:0]   rd_idx_i,
  input  dc_off_t      [`DC_NUM_PORTS-1:0]   rd_off_i,
  output dc_port_vec_t                       rd_ack_o,
  // refill
  input  logic                               wr_cl_vld_i,
  input  dc_way_vec_t                        wr_cl_we_i,
  input  dc_idx_t                            wr_cl_idx_i,
  // single word write
  input  dc_way_vec_t                        wr_req_i,
  input  dc_idx_t                            wr_idx_i,
  input  dc_off_t                            wr_off_i,
  output logic                               wr_ack_o,
  // towards the arrays
  output bank_op_e                           bank_op_o,
  output dc_bank_vec_t                       bank_req_o,
  output dc_bank_vec_t                       bank_we_o,
  output dc_idx_t      [`DC_NUM_BANKS-1:0]   bank_idx_o,
  output dc_way_vec_t                        bank_way_we_o,
  output dc_way_vec_t                        tag_req_o,
  output dc_idx_t                            tag_idx_o,
  // lookup context for the hit stage
  output dc_port_sel_t                       lkp_sel_o,
  output dc_idx_t                            lkp_idx_o,
  output dc_off_t                            lkp_off_o
);

  dc_port_vec_t rd_req_prio;
  dc_port_vec_t rd_req_masked;
  dc_port_sel_t rr_q, rr_d;
  dc_port_sel_t win;
  logic         found;
  logic         rd_acked;
  logic         bank_collision;

  //////////////////////////////
  // arbitration
  //////////////////////////////

  // any high prio request shuts out the low prio ones
  assign rd_req_prio   = rd_req_i & rd_prio_i;
  assign rd_req_masked = (|rd_req_prio) ? rd_req_prio : rd_req_i;

  // first competitor at or after the pointer, wrapping around
  always_comb begin : p_rr_pick
    int unsigned cand;
    found = 1'b0;
    win   = rr_q;
    for (int unsigned i = 0; i < `DC_NUM_PORTS; i++) begin
      cand = (rr_q + i) % `DC_NUM_PORTS;
      if (!found && rd_req_masked[cand]) begin
        found = 1'b1;
        win   = dc_port_sel_t'(cand);
      end
    end
  end

  // a refill owns the arrays for the whole cycle
  assign rd_acked = found & ~wr_cl_vld_i;

  always_comb begin : p_rd_ack
    rd_ack_o = '0;
    if (rd_acked) begin
      rd_ack_o[win] = 1'b1;
    end
  end

  assign rr_d = (win == dc_port_sel_t'(`DC_NUM_PORTS-1)) ? '0 : win + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_acked) begin
      rr_q <= rr_d;
    end
  end

  assign lkp_sel_o = win;
  assign lkp_idx_o = rd_idx_i[win];
  assign lkp_off_o = rd_off_i[win];

  //////////////////////////////
  // bank operation decode
  //////////////////////////////

  always_comb begin : p_bank_op
    if (wr_cl_vld_i) begin
      bank_op_o = BANK_REFILL;
    end else if (rd_acked) begin
      bank_op_o = rd_tag_only_i[win] ? BANK_TAG_READ : BANK_READ;
    end else begin
      bank_op_o = BANK_IDLE;
    end
  end

  assign tag_req_o = wr_cl_vld_i ? wr_cl_we_i : {`DC_SET_ASSOC{rd_acked}};
  assign tag_idx_o = wr_cl_vld_i ? wr_cl_idx_i : lkp_idx_o;

  // word write may share the cycle unless the read needs the same bank
  assign bank_collision = rd_acked & ~rd_tag_only_i[win] & (lkp_off_o == wr_off_i);
  assign wr_ack_o       = (|wr_req_i) & ~wr_cl_vld_i & ~bank_collision;
  assign bank_way_we_o  = wr_ack_o ? wr_req_i : '0;

  always_comb begin : p_bank_req
    bank_req_o = '0;
    bank_we_o  = '0;
    for (int k = 0; k < `DC_NUM_BANKS; k++) begin
      bank_idx_o[k] = wr_idx_i;
    end
    if (wr_cl_vld_i) begin
      // whole line goes in, every bank busy
      bank_req_o = '1;
      bank_we_o  = '1;
      for (int k = 0; k < `DC_NUM_BANKS; k++) begin
        bank_idx_o[k] = wr_cl_idx_i;
      end
    end else begin
      if (rd_acked && !rd_tag_only_i[win]) begin
        bank_req_o[lkp_off_o] = 1'b1;
        bank_idx_o[lkp_off_o] = lkp_idx_o;
      end
      if (wr_ack_o) begin
        bank_req_o[wr_off_i] = 1'b1;
        bank_we_o[wr_off_i]  = 1'b1;
      end
    end
  end

endmodule

/* src/dcache_arrays.sv */
//////////////////////////////
// tag and valid arrays per way, data
// banks per word offset, registered reads
//////////////////////////////

`include "dcache_mem_defs.svh"

module dcache_arrays import dcache_mem_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // control from the arbiter
  input  bank_op_e                                     bank_op_i,
  input  dc_bank_vec_t                                 bank_req_i,
  input  dc_bank_vec_t                                 bank_we_i,
  input  dc_idx_t     [`DC_NUM_BANKS-1:0]              bank_idx_i,
  input  dc_way_vec_t                                  bank_way_we_i,
  input  dc_way_vec_t                                  tag_req_i,
  input  dc_idx_t                                      tag_idx_i,
  // write data
  input  dc_way_vec_t                                  wr_cl_we_i,
  input  dc_tag_t                                      wr_cl_tag_i,
  input  dc_line_t                                     wr_cl_data_i,
  input  dc_way_vec_t                                  wr_vld_bits_i,
  input  dc_word_t                                     wr_data_i,
  // read data, one cycle after the request
  output dc_tag_t     [`DC_SET_ASSOC-1:0]              tag_rdata_o,
  output dc_way_vec_t                                  vld_rdata_o,
  output dc_word_t    [`DC_NUM_BANKS-1:0][`DC_SET_ASSOC-1:0] bank_rdata_o
);

  logic        refill;
  logic        lookup;
  dc_way_vec_t tag_write;
  dc_way_vec_t tag_read;
  dc_way_vec_t way_we;

  assign refill = (bank_op_i == BANK_REFILL);
  assign lookup = (bank_op_i == BANK_READ) || (bank_op_i == BANK_TAG_READ);

  assign tag_write = refill ? tag_req_i : '0;
  assign tag_read  = lookup ? tag_req_i : '0;

  // refill picks ways by wr_cl_we_i, word write by its one-hot vector
  assign way_we = refill ? wr_cl_we_i : bank_way_we_i;

  //////////////////////////////
  // tag and valid storage
  //////////////////////////////

  for (genvar w = 0; w < `DC_SET_ASSOC; w++) begin : gen_tag_way
    dc_tag_t                 tag_mem [`DC_NUM_SETS];
    logic [`DC_NUM_SETS-1:0] vld_q;
    dc_tag_t                 tag_rd_q;
    logic                    vld_rd_q;

    always_ff @(posedge clk_i) begin : p_tag_mem
      if (tag_write[w]) begin
        tag_mem[tag_idx_i] <= wr_cl_tag_i;
      end
      if (tag_read[w]) begin
        tag_rd_q <= tag_mem[tag_idx_i];
      end
    end

    // valid bits start cleared so an empty cache never hits
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld
      if (!rst_ni) begin
        vld_q    <= '0;
        vld_rd_q <= 1'b0;
      end else begin
        if (tag_write[w]) begin
          vld_q[tag_idx_i] <= wr_vld_bits_i[w];
        end
        if (tag_read[w]) begin
          vld_rd_q <= vld_q[tag_idx_i];
        end
      end
    end

    assign tag_rdata_o[w] = tag_rd_q;
    assign vld_rdata_o[w] = vld_rd_q;
  end

  //////////////////////////////
  // data banks
  //////////////////////////////

  for (genvar k = 0; k < `DC_NUM_BANKS; k++) begin : gen_bank
    dc_word_t wdata;

    assign wdata = refill ? wr_cl_data_i[k] : wr_data_i;

    for (genvar w = 0; w < `DC_SET_ASSOC; w++) begin : gen_bank_way
      dc_word_t data_mem [`DC_NUM_SETS];
      dc_word_t rdata_q;

      always_ff @(posedge clk_i) begin : p_data_mem
        if (bank_req_i[k] && bank_we_i[k] && way_we[w]) begin
          data_mem[bank_idx_i[k]] <= wdata;
        end
        // read only on a non-write access of this bank
        if (bank_req_i[k] && !bank_we_i[k]) begin
          rdata_q <= data_mem[bank_idx_i[k]];
        end
      end

      assign bank_rdata_o[k][w] = rdata_q;
    end
  end

endmodule

/* src/dcache_hit_select.sv */
//////////////////////////////
// lookup context regs, tag compare
// and hit word readout
//////////////////////////////

`include "dcache_mem_defs.svh"

module dcache_hit_select import dcache_mem_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // lookup context of the granted read
  input  bank_op_e                                     bank_op_i,
  input  dc_port_sel_t                                 lkp_sel_i,
  input  dc_off_t                                      lkp_off_i,
  // late tags, one cycle after the grant
  input  dc_tag_t     [`DC_NUM_PORTS-1:0]              rd_tag_i,
  // array read data
  input  dc_tag_t     [`DC_SET_ASSOC-1:0]              tag_rdata_i,
  input  dc_way_vec_t                                  vld_rdata_i,
  input  dc_word_t    [`DC_NUM_BANKS-1:0][`DC_SET_ASSOC-1:0] bank_rdata_i,
  // lookup result
  output dc_way_vec_t                                  rd_hit_oh_o,
  output dc_way_vec_t                                  rd_vld_bits_o,
  output dc_word_t                                     rd_data_o
);

  dc_port_sel_t sel_q;
  dc_off_t      off_q;
  logic         cmp_en_d, cmp_en_q;
  dc_tag_t      rd_tag;

  // compare only after a read or tag read reached the arrays
  assign cmp_en_d = (bank_op_i == BANK_READ) || (bank_op_i == BANK_TAG_READ);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lkp_regs
    if (!rst_ni) begin
      sel_q    <= '0;
      off_q    <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      sel_q    <= lkp_sel_i;
      off_q    <= lkp_off_i;
      cmp_en_q <= cmp_en_d;
    end
  end

  // tag of the port granted last cycle
  assign rd_tag = rd_tag_i[sel_q];

  for (genvar w = 0; w < `DC_SET_ASSOC; w++) begin : gen_cmp
    assign rd_hit_oh_o[w] = cmp_en_q & vld_rdata_i[w] & (tag_rdata_i[w] == rd_tag);
  end

  assign rd_vld_bits_o = vld_rdata_i;

  // and-or mux over the ways of the offset's bank gives zero on a miss
  always_comb begin : p_rd_data
    rd_data_o = '0;
    for (int w = 0; w < `DC_SET_ASSOC; w++) begin
      if (rd_hit_oh_o[w]) begin
        rd_data_o = rd_data_o | bank_rdata_i[off_q][w];
      end
    end
  end

endmodule

/* src/dcache_mem.sv */
//////////////////////////////
// storage core of the write-through
// l1 dcache with arbiter, arrays
// and hit stage
//////////////////////////////

`include "dcache_mem_defs.svh"

module dcache_mem import dcache_mem_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // read ports with the tag one cycle after the grant
  input  dc_tag_t      [`DC_NUM_PORTS-1:0]  rd_tag_i,
  input  dc_idx_t      [`DC_NUM_PORTS-1:0]  rd_idx_i,
  input  dc_off_t      [`DC_NUM_PORTS-1:0]  rd_off_i,
  input  dc_port_vec_t                      rd_req_i,
  input  dc_port_vec_t                      rd_tag_only_i,
  input  dc_port_vec_t                      rd_prio_i,
  output dc_port_vec_t                      rd_ack_o,
  output dc_way_vec_t                       rd_vld_bits_o,
  output dc_way_vec_t                       rd_hit_oh_o,
  output dc_word_t                          rd_data_o,
  // cache line refill
  input  logic                              wr_cl_vld_i,
  input  dc_way_vec_t                       wr_cl_we_i,
  input  dc_tag_t                           wr_cl_tag_i,
  input  dc_idx_t                           wr_cl_idx_i,
  input  dc_line_t                          wr_cl_data_i,
  input  dc_way_vec_t                       wr_vld_bits_i,
  // single word write, no tag access
  input  dc_way_vec_t                       wr_req_i,
  output logic                              wr_ack_o,
  input  dc_idx_t                           wr_idx_i,
  input  dc_off_t                           wr_off_i,
  input  dc_word_t                          wr_data_i
);

  bank_op_e                                     bank_op;
  dc_bank_vec_t                                 bank_req, bank_we;
  dc_idx_t      [`DC_NUM_BANKS-1:0]             bank_idx;
  dc_way_vec_t                                  bank_way_we, tag_req, vld_rdata;
  dc_idx_t                                      tag_idx;
  dc_port_sel_t                                 lkp_sel;
  dc_off_t                                      lkp_off;
  dc_tag_t      [`DC_SET_ASSOC-1:0]             tag_rdata;
  dc_word_t     [`DC_NUM_BANKS-1:0][`DC_SET_ASSOC-1:0] bank_rdata;

  dcache_req_arbiter u_arbiter (
    .clk_i, .rst_ni, .rd_req_i, .rd_prio_i, .rd_tag_only_i, .rd_idx_i, .rd_off_i,
    .rd_ack_o, .wr_cl_vld_i, .wr_cl_we_i, .wr_cl_idx_i, .wr_req_i, .wr_idx_i,
    .wr_off_i, .wr_ack_o,
    .bank_op_o (bank_op), .bank_req_o (bank_req), .bank_we_o (bank_we),
    .bank_idx_o (bank_idx), .bank_way_we_o (bank_way_we), .tag_req_o (tag_req),
    .tag_idx_o (tag_idx), .lkp_sel_o (lkp_sel), .lkp_idx_o (), .lkp_off_o (lkp_off)
  );

  dcache_arrays u_arrays (
    .clk_i, .rst_ni, .bank_op_i (bank_op), .bank_req_i (bank_req), .bank_we_i (bank_we),
    .bank_idx_i (bank_idx), .bank_way_we_i (bank_way_we), .tag_req_i (tag_req),
    .tag_idx_i (tag_idx), .wr_cl_we_i, .wr_cl_tag_i, .wr_cl_data_i, .wr_vld_bits_i,
    .wr_data_i, .tag_rdata_o (tag_rdata), .vld_rdata_o (vld_rdata),
    .bank_rdata_o (bank_rdata)
  );

  dcache_hit_select u_hit_select (
    .clk_i, .rst_ni, .bank_op_i (bank_op), .lkp_sel_i (lkp_sel), .lkp_off_i (lkp_off),
    .rd_tag_i, .tag_rdata_i (tag_rdata), .vld_rdata_i (vld_rdata),
    .bank_rdata_i (bank_rdata), .rd_hit_oh_o, .rd_vld_bits_o, .rd_data_o
  );

endmodule

/* testbench/dcache_mem_chk.sv */
//////////////////////////////
// bound assertions on read grant
// and hit vector one-hotness
//////////////////////////////

`include "dcache_mem_defs.svh"

module dcache_mem_chk import dcache_mem_pkg::*; (
  input logic         clk_i,
  input logic         rst_ni,
  input dc_port_vec_t rd_ack_i,
  input dc_way_vec_t  rd_hit_oh_i,
  input logic         wr_ack_i,
  input dc_way_vec_t  wr_req_i,
  input logic         wr_cl_vld_i
);

  int unsigned fail_cnt = 0;

  // at most one read port wins per cycle
  a_rd_ack_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_ack_i))
  else begin
    $error("more than one read grant");
    fail_cnt++;
  end

  // a line never sits in two ways with the same tag
  a_hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_hit_oh_i))
  else begin
    $error("hit vector is not one-hot");
    fail_cnt++;
  end

  a_wr_way_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_ack_i |-> $onehot0(wr_req_i))
  else begin
    $error("word write to several ways");
    fail_cnt++;
  end

  // refill blocks every lookup
  a_no_ack_in_refill : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_cl_vld_i |-> (rd_ack_i == '0))
  else begin
    $error("read granted during refill");
    fail_cnt++;
  end

endmodule

/* testbench/dcache_mem_tb.sv */
//////////////////////////////
// directed testbench for the dcache
// storage core with a reference model
//////////////////////////////

`include "dcache_mem_defs.svh"

module dcache_mem_tb import dcache_mem_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  localparam int ACK_WAIT = 8;
  // cycle budget of reset and of each test in turn
  localparam int TEST_CYCLES = RESET_CYCLES + 30 + 8 + 14 + 12 + 20;
  localparam int MARGIN_CYCLES = 100;

  logic clk_i, rst_ni;
  dc_tag_t      [`DC_NUM_PORTS-1:0] rd_tag_i;
  dc_idx_t      [`DC_NUM_PORTS-1:0] rd_idx_i;
  dc_off_t      [`DC_NUM_PORTS-1:0] rd_off_i;
  dc_port_vec_t rd_req_i, rd_tag_only_i, rd_prio_i, rd_ack_o;
  dc_way_vec_t  rd_vld_bits_o, rd_hit_oh_o;
  dc_word_t     rd_data_o;
  logic         wr_cl_vld_i;
  dc_way_vec_t  wr_cl_we_i, wr_vld_bits_i, wr_req_i;
  dc_tag_t      wr_cl_tag_i;
  dc_idx_t      wr_cl_idx_i, wr_idx_i;
  dc_line_t     wr_cl_data_i;
  logic         wr_ack_o;
  dc_off_t      wr_off_i;
  dc_word_t     wr_data_i;

  // reference model of the arrays and the round-robin pointer
  dc_tag_t  tag_m  [`DC_SET_ASSOC][`DC_NUM_SETS];
  logic     vld_m  [`DC_SET_ASSOC][`DC_NUM_SETS];
  dc_word_t word_m [`DC_NUM_BANKS][`DC_SET_ASSOC][`DC_NUM_SETS];
  int       rr_m;

  integer  seed = 78960;
  int      val_err = 0;
  int      hs_err = 0;
  dc_tag_t tag_a, tag_b;

  dcache_mem dut0 (.*);

  bind dcache_mem dcache_mem_chk u_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .rd_ack_i(rd_ack_o), .rd_hit_oh_i(rd_hit_oh_o),
    .wr_ack_i(wr_ack_o), .wr_req_i(wr_req_i), .wr_cl_vld_i(wr_cl_vld_i)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic drive_point();
    @(posedge clk_i);
    #10;
  endtask

  task automatic report_fail(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    val_err++;
  endtask

  // winner by the masking rule, scanning upward from the pointer
  function automatic int next_grant(input dc_port_vec_t req, input dc_port_vec_t prio,
                                    input int ptr);
    dc_port_vec_t cand;
    int port;
    cand = req & prio;
    if (cand == '0) cand = req;
    next_grant = -1;
    for (int i = `DC_NUM_PORTS - 1; i >= 0; i--) begin
      port = ptr + i;
      if (port >= `DC_NUM_PORTS) port -= `DC_NUM_PORTS;
      if (cand[port]) next_grant = port;
    end
  endfunction

  task automatic refill_line(input dc_way_vec_t we, input dc_idx_t idx, input dc_tag_t tag,
                             input dc_way_vec_t vld_bits, input string name);
    dc_line_t line;
    drive_point();
    for (int k = 0; k < `DC_NUM_BANKS; k++) line[k] = $random(seed);
    wr_cl_vld_i = 1'b1;
    wr_cl_we_i = we;
    wr_cl_idx_i = idx;
    wr_cl_tag_i = tag;
    wr_cl_data_i = line;
    wr_vld_bits_i = vld_bits;
    #30;
    if (rd_ack_o !== '0) report_fail({name, " grant"}, 0, rd_ack_o);
    for (int w = 0; w < `DC_SET_ASSOC; w++) begin
      if (we[w]) begin
        tag_m[w][idx] = tag;
        vld_m[w][idx] = vld_bits[w];
        for (int k = 0; k < `DC_NUM_BANKS; k++) word_m[k][w][idx] = line[k];
      end
    end
    drive_point();
    wr_cl_vld_i = 1'b0;
    wr_cl_we_i = '0;
  endtask

  task automatic read_check(input int p, input dc_idx_t idx, input dc_off_t off,
                            input dc_tag_t tag, input logic tag_only, input string name);
    int waited;
    dc_way_vec_t exp_hit;
    dc_way_vec_t exp_vld;
    dc_word_t exp_data;
    drive_point();
    rd_req_i[p] = 1'b1;
    rd_idx_i[p] = idx;
    rd_off_i[p] = off;
    rd_tag_only_i[p] = tag_only;
    waited = 0;
    #30;
    while (!rd_ack_o[p] && waited < ACK_WAIT) begin
      @(posedge clk_i);
      #40;
      waited++;
    end
    if (!rd_ack_o[p]) begin
      $display("%s: read port %0d was never granted", name, p);
      hs_err++;
      drive_point();
      rd_req_i[p] = 1'b0;
    end else begin
      rr_m = (p + 1) % `DC_NUM_PORTS;
      exp_data = '0;
      for (int w = 0; w < `DC_SET_ASSOC; w++) begin
        exp_vld[w] = vld_m[w][idx];
        exp_hit[w] = vld_m[w][idx] && (tag_m[w][idx] == tag);
        if (exp_hit[w]) exp_data = word_m[off][w][idx];
      end
      // late tag arrives in the cycle after the grant
      drive_point();
      rd_req_i[p] = 1'b0;
      rd_tag_i[p] = tag;
      #30;
      if (rd_hit_oh_o !== exp_hit) report_fail({name, " hit"}, exp_hit, rd_hit_oh_o);
      if (rd_vld_bits_o !== exp_vld) report_fail({name, " vld"}, exp_vld, rd_vld_bits_o);
      if (!tag_only && rd_data_o !== exp_data) report_fail({name, " data"}, exp_data, rd_data_o);
    end
  endtask

  task automatic write_word(input dc_way_vec_t way, input dc_idx_t idx, input dc_off_t off,
                            input string name);
    int waited;
    drive_point();
    wr_req_i = way;
    wr_idx_i = idx;
    wr_off_i = off;
    wr_data_i = $random(seed);
    waited = 0;
    #30;
    while (!wr_ack_o && waited < ACK_WAIT) begin
      @(posedge clk_i);
      #40;
      waited++;
    end
    if (!wr_ack_o) begin
      $display("%s: word write was never acknowledged", name);
      hs_err++;
    end else begin
      for (int w = 0; w < `DC_SET_ASSOC; w++) if (way[w]) word_m[off][w][idx] = wr_data_i;
    end
    drive_point();
    wr_req_i = '0;
  endtask

  // read on port 0 and word write to way 1 in the same cycle
  task automatic collide(input logic tag_only, input dc_off_t rd_off, input dc_off_t wr_off,
                         input logic exp_ack, input string name);
    drive_point();
    rd_req_i[0] = 1'b1;
    rd_idx_i[0] = 4'd9;
    rd_off_i[0] = rd_off;
    rd_tag_only_i[0] = tag_only;
    wr_req_i = 4'b0010;
    wr_idx_i = 4'd9;
    wr_off_i = wr_off;
    wr_data_i = $random(seed);
    #30;
    if (rd_ack_o !== 3'b001) report_fail({name, " grant"}, 3'b001, rd_ack_o);
    if (wr_ack_o !== exp_ack) report_fail({name, " wr_ack"}, exp_ack, wr_ack_o);
    if (exp_ack) word_m[wr_off][1][9] = wr_data_i;
    rr_m = 1;
    drive_point();
    rd_req_i = '0;
    rd_tag_only_i = '0;
    rd_tag_i[0] = tag_b;
    wr_req_i = '0;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_refill_hit();
    refill_line(4'b0100, 4'd5, tag_a, 4'b0100, "refill_hit");
    for (int p = 0; p < `DC_NUM_PORTS; p++) begin
      for (int off = 0; off < `DC_NUM_BANKS; off++) begin
        read_check(p, 4'd5, dc_off_t'(off), tag_a, 1'b0, "refill_hit");
      end
    end
  endtask

  task automatic test_miss_tag_only();
    read_check(1, 4'd5, 2'd2, tag_a ^ 8'h5a, 1'b0, "miss");
    read_check(0, 4'd6, 2'd1, tag_a, 1'b0, "miss_empty_set");
    read_check(2, 4'd5, 2'd0, tag_a, 1'b1, "tag_only");
  endtask

  task automatic test_word_write();
    write_word(4'b0100, 4'd5, 2'd3, "word_write");
    for (int off = 0; off < `DC_NUM_BANKS; off++) begin
      read_check(0, 4'd5, dc_off_t'(off), tag_a, 1'b0, "word_write");
    end
  endtask

  task automatic test_arbitration();
    int g;
    dc_port_vec_t exp_ack;
    drive_point();
    rd_req_i = '1;
    rd_tag_only_i = '0;
    for (int p = 0; p < `DC_NUM_PORTS; p++) begin
      rd_idx_i[p] = 4'd5;
      rd_off_i[p] = dc_off_t'(p);
      rd_tag_i[p] = tag_a;
    end
    for (int c = 0; c < 9; c++) begin
      rd_prio_i = (c >= 3 && c < 6) ? 3'b110 : ((c >= 7) ? 3'b001 : 3'b000);
      // refill with no way enabled blocks reads and writes nothing
      wr_cl_vld_i = (c == 6);
      #30;
      g = next_grant(rd_req_i, rd_prio_i, rr_m);
      exp_ack = '0;
      if (!wr_cl_vld_i) exp_ack[g] = 1'b1;
      if (rd_ack_o !== exp_ack) report_fail("arbitration", exp_ack, rd_ack_o);
      if (exp_ack != '0) rr_m = (g + 1) % `DC_NUM_PORTS;
      drive_point();
    end
    rd_req_i = '0;
    rd_prio_i = '0;
    wr_cl_vld_i = 1'b0;
  endtask

  task automatic test_collision();
    refill_line(4'b0010, 4'd9, tag_b, 4'b0010, "collision_refill");
    collide(1'b0, 2'd1, 2'd1, 1'b0, "collision_same_bank");
    collide(1'b1, 2'd1, 2'd1, 1'b1, "collision_tag_only");
    collide(1'b0, 2'd1, 2'd2, 1'b1, "collision_other_bank");
    for (int off = 0; off < `DC_NUM_BANKS; off++) begin
      read_check(0, 4'd9, dc_off_t'(off), tag_b, 1'b0, "collision_readback");
    end
  endtask

  initial begin : main
    rst_ni = 1'b0;
    rd_tag_i = '0;
    rd_idx_i = '0;
    rd_off_i = '0;
    rd_req_i = '0;
    rd_tag_only_i = '0;
    rd_prio_i = '0;
    wr_cl_vld_i = 1'b0;
    wr_cl_we_i = '0;
    wr_cl_tag_i = '0;
    wr_cl_idx_i = '0;
    wr_cl_data_i = '0;
    wr_vld_bits_i = '0;
    wr_req_i = '0;
    wr_idx_i = '0;
    wr_off_i = '0;
    wr_data_i = '0;
    rr_m = 0;
    for (int w = 0; w < `DC_SET_ASSOC; w++) begin
      for (int s = 0; s < `DC_NUM_SETS; s++) vld_m[w][s] = 1'b0;
    end
    tag_a = dc_tag_t'($random(seed));
    tag_b = dc_tag_t'($random(seed));
    repeat (RESET_CYCLES) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    #30;
    if (rd_hit_oh_o !== '0) report_fail("reset", 0, rd_hit_oh_o);
    test_refill_hit();
    test_miss_tag_only();
    test_word_write();
    test_arbitration();
    test_collision();
    drive_point();
    $display("value errors: %0d, handshake errors: %0d, assertion errors: %0d",
             val_err, hs_err, dut0.u_chk.fail_cnt);
    if (val_err + hs_err + dut0.u_chk.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* tb.f */
+incdir+src
src/dcache_mem_pkg.sv
src/dcache_req_arbiter.sv
src/dcache_arrays.sv
src/dcache_hit_select.sv
src/dcache_mem.sv
testbench/dcache_mem_chk.sv
testbench/dcache_mem_tb.sv
